// ==== src/kmc_settings.svh ====
////////////////////
// Build constants for the KMC data path
// MAR carries one bit above the RAM address to flag a wrap on increment
// Field widths below must add up to KMC_CRAM_WIDTH
////////////////////
`ifndef KMC_SETTINGS_SVH
`define KMC_SETTINGS_SVH

// Byte-wide data path
`define KMC_DATA_WIDTH 8

// 1K byte scratch RAM
`define KMC_MEM_DEPTH 1024

// RAM address plus the wrap bit
`define KMC_MAR_WIDTH 11

// One control RAM word
`define KMC_CRAM_WIDTH 20

// Control word field widths
`define KMC_SRC_WIDTH 3
`define KMC_ALUOP_WIDTH 4
`define KMC_DST_WIDTH 3
`define KMC_MAROP_WIDTH 2

`endif

// ==== src/kmc_pkg.sv ====
////////////////////
// Control word layout and field encodings
// Field widths come from kmc_settings.svh
// Codes not listed in an enum are unused
////////////////////
`include "kmc_settings.svh"

package kmc_pkg;

   // Operand source
   // SRC_JMP is the branch class and never a move
   typedef enum logic [`KMC_SRC_WIDTH-1:0] {
      SRC_IMMED = 3'd0,
      SRC_IBUS  = 3'd1,
      SRC_MEM   = 3'd2,
      SRC_BRG   = 3'd3,
      SRC_JMP   = 3'd4
   } kmcSrc_t;

   // Result destination
   typedef enum logic [`KMC_DST_WIDTH-1:0] {
      DST_NONE = 3'd0,
      DST_MEM  = 3'd1,
      DST_BRG  = 3'd2,
      DST_OBUS = 3'd3
   } kmcDst_t;

   // Address register action
   typedef enum logic [`KMC_MAROP_WIDTH-1:0] {
      MAR_HOLD = 2'd0,
      MAR_LDLO = 2'd1,
      MAR_LDHI = 2'd2,
      MAR_INC  = 2'd3
   } kmcMarOp_t;

   // ALU function
   typedef enum logic [`KMC_ALUOP_WIDTH-1:0] {
      ALU_PASS = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_NOT  = 4'd6,
      ALU_INC  = 4'd7
   } kmcAluOp_t;

   // Full control word, src in the top bits
   typedef struct packed {
      kmcSrc_t                    src;
      kmcAluOp_t                  aluOp;
      kmcDst_t                    dst;
      kmcMarOp_t                  marOp;
      logic [`KMC_DATA_WIDTH-1:0] imm;
   } kmcCram_t;

endpackage

// ==== src/kmcSrcSel.sv ====
////////////////////
// ALU operand selector
// Purely combinational
// SRC_JMP and unused codes fall back to the immediate field
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcSrcSel
(
   input  kmc_pkg::kmcSrc_t           src,
   input  logic [`KMC_DATA_WIDTH-1:0] imm,
   input  logic [`KMC_DATA_WIDTH-1:0] ibus,
   input  logic [`KMC_DATA_WIDTH-1:0] memData,
   input  logic [`KMC_DATA_WIDTH-1:0] brg,
   output logic [`KMC_DATA_WIDTH-1:0] operand
);

   import kmc_pkg::*;

   // Four-way source mux
   always_comb
   begin
      case (src)
         // Literal from the control word
         SRC_IMMED: operand = imm;
         // External input bus level
         SRC_IBUS:  operand = ibus;
         // Registered RAM read at the previous MAR
         SRC_MEM:   operand = memData;
         // Bridge register feedback
         SRC_BRG:   operand = brg;
         // Branch word, value goes nowhere
         default:   operand = imm;
      endcase
   end

endmodule

// ==== src/kmcAlu.sv ====
////////////////////
// 8-bit ALU with the bridge and output bus registers
// BRG is the second operand of every two-operand function
// No flags, results wrap modulo 256
// Registers change only on a stepped move word
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcAlu
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       init,
   input  logic                       step,
   input  kmc_pkg::kmcCram_t          cram,
   input  logic [`KMC_DATA_WIDTH-1:0] operand,
   output logic [`KMC_DATA_WIDTH-1:0] result,
   output logic [`KMC_DATA_WIDTH-1:0] brg,
   output logic [`KMC_DATA_WIDTH-1:0] obus
);

   import kmc_pkg::*;

   // Move decode
   logic isMove;
   // Register load enables
   logic brgLoad;
   logic obusLoad;

   // Any source except the branch class is a move
   assign isMove = (cram.src != SRC_JMP);

   assign brgLoad  = step && isMove && (cram.dst == DST_BRG);
   assign obusLoad = step && isMove && (cram.dst == DST_OBUS);

   ////////////////////
   // Function unit
   ////////////////////

   // Carries out of bit 7 are dropped
   always_comb
   begin
      case (cram.aluOp)
         ALU_PASS: result = operand;
         ALU_ADD:  result = operand + brg;
         // Operand minus BRG
         ALU_SUB:  result = operand - brg;
         ALU_AND:  result = operand & brg;
         ALU_OR:   result = operand | brg;
         ALU_XOR:  result = operand ^ brg;
         // Single operand functions
         ALU_NOT:  result = ~operand;
         ALU_INC:  result = operand + 1'b1;
         // Unused codes act as pass
         default:  result = operand;
      endcase
   end

   ////////////////////
   // Bridge and output registers
   ////////////////////

   // Init clears both like reset
   always_ff @(posedge clk)
   begin
      if (rst || init)
      begin
         brg  <= '0;
         obus <= '0;
      end
      else
      begin
         if (brgLoad)
            brg <= result;
         // Output bus holds until the next OBUS move
         if (obusLoad)
            obus <= result;
      end
   end

endmodule

// ==== src/kmcMem.sv ====
////////////////////
// MAR and 1K byte RAM with registered read
// memData shows the RAM at the previous cycle's MAR
// A write needs one idle cycle before it shows on memData
// RAM contents survive init
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcMem
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       init,
   input  logic                       step,
   input  kmc_pkg::kmcCram_t          cram,
   input  logic [`KMC_DATA_WIDTH-1:0] result,
   output logic [`KMC_MAR_WIDTH-1:0]  mar,
   output logic [`KMC_DATA_WIDTH-1:0] memData
);

   import kmc_pkg::*;

   // RAM address bits below the wrap bit
   localparam int AddrWidth = $clog2(`KMC_MEM_DEPTH);

   logic                       isMove;
   logic                       marEn;
   logic                       memWr;
   logic [AddrWidth-1:0]       ramAddr;
   // Zero at start of simulation
   logic [`KMC_DATA_WIDTH-1:0] ram [0:`KMC_MEM_DEPTH-1] = '{default: '0};

   // Branch words reuse the MAR field, so only moves act on it
   assign isMove  = (cram.src != SRC_JMP);
   assign marEn   = step && isMove;
   assign memWr   = marEn && (cram.dst == DST_MEM);
   assign ramAddr = mar[AddrWidth-1:0];

   ////////////////////
   // Address register
   ////////////////////

   // Top bit is reachable only through INC
   always_ff @(posedge clk)
   begin
      if (rst || init)
         mar <= '0;
      else if (marEn)
      begin
         case (cram.marOp)
            // Low byte straight from the ALU
            MAR_LDLO: mar[`KMC_DATA_WIDTH-1:0] <= result;
            // Two page bits, wrap bit forced low
            MAR_LDHI: mar[`KMC_MAR_WIDTH-1:`KMC_DATA_WIDTH] <= {1'b0, result[1:0]};
            // Rolls 2047 over to 0
            MAR_INC:  mar <= mar + 1'b1;
            default:  mar <= mar;
         endcase
      end
   end

   ////////////////////
   // RAM
   ////////////////////

   // Write uses the MAR from before this step's update
   always_ff @(posedge clk)
   begin
      if (memWr)
         ram[ramAddr] <= result;
   end

   // Read-before-write on a same-edge collision
   always_ff @(posedge clk)
   begin
      if (rst || init)
         memData <= '0;
      else
         memData <= ram[ramAddr];
   end

endmodule

// ==== src/kmcDatapath.sv ====
////////////////////
// KMC data path top level
// Host must leave one idle cycle between steps
// cram is sampled only while step is high
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcDatapath
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       init,
   input  logic                       step,
   input  kmc_pkg::kmcCram_t          cram,
   input  logic [`KMC_DATA_WIDTH-1:0] ibus,
   output logic [`KMC_MAR_WIDTH-1:0]  mar,
   output logic [`KMC_DATA_WIDTH-1:0] memData,
   output logic [`KMC_DATA_WIDTH-1:0] brg,
   output logic [`KMC_DATA_WIDTH-1:0] obus
);

   // Selected ALU input
   logic [`KMC_DATA_WIDTH-1:0] operand;
   // ALU output to registers and RAM
   logic [`KMC_DATA_WIDTH-1:0] result;

   // Operand from immediate, input bus, RAM or bridge
   kmcSrcSel uSrcSel (
      .src     (cram.src),
      .imm     (cram.imm),
      .ibus    (ibus),
      .memData (memData),
      .brg     (brg),
      .operand (operand)
   );

   // ALU with BRG and OBUS
   kmcAlu uAlu (
      .clk     (clk),
      .rst     (rst),
      .init    (init),
      .step    (step),
      .cram    (cram),
      .operand (operand),
      .result  (result),
      .brg     (brg),
      .obus    (obus)
   );

   // MAR and RAM
   kmcMem uMem (
      .clk     (clk),
      .rst     (rst),
      .init    (init),
      .step    (step),
      .cram    (cram),
      .result  (result),
      .mar     (mar),
      .memData (memData)
   );

endmodule

// ==== dv/kmcDatapath_sva.sv ====
////////////////////
// Bound checks on the KMC data path
// init clears state the way rst does
// MAR wrap bit may be cleared by LDHI or init
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcDatapathSva
(
   input logic                       clk,
   input logic                       rst,
   input logic                       init,
   input logic                       step,
   input kmc_pkg::kmcCram_t          cram,
   input logic [`KMC_MAR_WIDTH-1:0]  mar,
   input logic [`KMC_DATA_WIDTH-1:0] brg,
   input logic [`KMC_DATA_WIDTH-1:0] obus
);

   import kmc_pkg::*;

   logic moveStep;
   logic incStep;
   logic ldhiStep;
   logic obusStep;

   assign moveStep = step && (cram.src != SRC_JMP);
   assign incStep  = moveStep && (cram.marOp == MAR_INC);
   assign ldhiStep = moveStep && (cram.marOp == MAR_LDHI);
   assign obusStep = moveStep && (cram.dst == DST_OBUS);

   // Wrap bit is set only by INC
   marTopBit: assert property (@(posedge clk) disable iff (rst)
      $changed(mar[`KMC_MAR_WIDTH-1]) |->
         ($past(incStep) || ($past(ldhiStep || init) && !mar[`KMC_MAR_WIDTH-1])))
      else $error("MAR bit 10 changed without an INC step");

   // Output bus holds between OBUS moves
   obusHold: assert property (@(posedge clk) disable iff (rst)
      !$stable(obus) |-> $past(obusStep || init))
      else $error("obus changed without a DST_OBUS move");

   // Registers are clear right after reset
   resetClear: assert property (@(posedge clk)
      rst |=> (brg == '0 && obus == '0))
      else $error("brg or obus not zero after reset");

endmodule

// ==== dv/kmcTb.sv ====
////////////////////
// Testbench for the KMC data path
// One idle cycle follows every step
// The reference model relies on that idle cycle
// Stops at the first mismatch
////////////////////
`timescale 1ns/100ps
`include "kmc_settings.svh"

module kmcTb;

   import kmc_pkg::*;

   // Step budget per section for the watchdog
   localparam int InitSteps   = 10;
   localparam int MarSteps    = 780;
   localparam int AluTrials   = 4;
   localparam int MemTrials   = 8;
   localparam int RandSteps   = 2000;
   localparam int PlannedSteps = InitSteps + MarSteps + 24 * AluTrials + 4 * MemTrials
                                 + RandSteps;
   localparam int TimeoutNs   = PlannedSteps * 30 + 10 * 10;

   // Model state with the whole RAM
   typedef struct packed {
      logic [`KMC_MAR_WIDTH-1:0]                     mar;
      logic [`KMC_DATA_WIDTH-1:0]                    brg;
      logic [`KMC_DATA_WIDTH-1:0]                    obus;
      logic [`KMC_MEM_DEPTH-1:0][`KMC_DATA_WIDTH-1:0] ram;
   } modelState_t;

   // Observed outputs
   typedef struct packed {
      logic [`KMC_MAR_WIDTH-1:0]  mar;
      logic [`KMC_DATA_WIDTH-1:0] memData;
      logic [`KMC_DATA_WIDTH-1:0] brg;
      logic [`KMC_DATA_WIDTH-1:0] obus;
   } kmcObs_t;

   logic                       clk = 1'b0;
   logic                       rst;
   logic                       init;
   logic                       step;
   kmcCram_t                   cram;
   logic [`KMC_DATA_WIDTH-1:0] ibus;
   logic [`KMC_MAR_WIDTH-1:0]  mar;
   logic [`KMC_DATA_WIDTH-1:0] memData;
   logic [`KMC_DATA_WIDTH-1:0] brg;
   logic [`KMC_DATA_WIDTH-1:0] obus;

   modelState_t model;
   kmcObs_t     expQ[$];
   string       nameQ[$];
   kmcObs_t     expObs;
   kmcObs_t     actObs;
   logic        stepD1 = 1'b0;
   logic        stepD2 = 1'b0;
   logic        clrD1  = 1'b0;

   kmcDatapath u_dut (
      .clk     (clk),
      .rst     (rst),
      .init    (init),
      .step    (step),
      .cram    (cram),
      .ibus    (ibus),
      .mar     (mar),
      .memData (memData),
      .brg     (brg),
      .obus    (obus)
   );

   bind kmcDatapath kmcDatapathSva uSva (
      .clk(clk), .rst(rst), .init(init), .step(step),
      .cram(cram), .mar(mar), .brg(brg), .obus(obus)
   );

   always #5 clk = ~clk;

   ////////////////////
   // Reference model
   ////////////////////

   // One control word applied to the model state
   function automatic modelState_t refStep(modelState_t s, kmcCram_t w, logic [7:0] ibusVal);
      modelState_t n;
      logic [7:0]  opnd;
      logic [7:0]  res;
      logic [8:0]  sum;
      logic [9:0]  addr;
      n    = s;
      addr = s.mar[9:0];
      case (w.src)
         SRC_IBUS: opnd = ibusVal;
         SRC_MEM:  opnd = s.ram[addr];
         SRC_BRG:  opnd = s.brg;
         default:  opnd = w.imm;
      endcase
      sum = 9'd0;
      case (w.aluOp)
         ALU_ADD: sum = {1'b0, opnd} + {1'b0, s.brg};
         // Two's complement subtract of BRG
         ALU_SUB: sum = {1'b0, opnd} + {1'b0, ~s.brg} + 9'd1;
         ALU_INC: sum = {1'b0, opnd} + 9'd1;
         default: sum = {1'b0, opnd};
      endcase
      case (w.aluOp)
         ALU_AND: res = opnd & s.brg;
         ALU_OR:  res = opnd | s.brg;
         ALU_XOR: res = opnd ^ s.brg;
         ALU_NOT: res = 8'hff ^ opnd;
         default: res = sum[7:0];
      endcase
      if (w.src != SRC_JMP)
      begin
         if (w.dst == DST_BRG)
            n.brg = res;
         if (w.dst == DST_OBUS)
            n.obus = res;
         // Write goes to the MAR before this step
         if (w.dst == DST_MEM)
            n.ram[addr] = res;
         case (w.marOp)
            MAR_LDLO: n.mar[7:0] = res;
            MAR_LDHI: n.mar[10:8] = {1'b0, res[1:0]};
            MAR_INC:  n.mar = (s.mar == 11'h7ff) ? 11'h000 : s.mar + 11'd1;
            default:  n.mar = s.mar;
         endcase
      end
      return n;
   endfunction

   function automatic kmcCram_t mkWord(kmcSrc_t s, kmcAluOp_t a, kmcDst_t d, kmcMarOp_t m,
                                       logic [7:0] imm);
      kmcCram_t w;
      w.src   = s;
      w.aluOp = a;
      w.dst   = d;
      w.marOp = m;
      w.imm   = imm;
      return w;
   endfunction

   ////////////////////
   // Checking
   ////////////////////

   task automatic checkEqual(string name, logic [31:0] expVal, logic [31:0] actVal);
      if (expVal !== actVal)
      begin
         $display("ERR test=%s expected=0x%0h actual=0x%0h", name, expVal, actVal);
         $display("CHECKS FAILED");
         $fatal(1, "Value mismatch in %s", name);
      end
   endtask

   task automatic compareObs(string name, kmcObs_t e, kmcObs_t a);
      checkEqual({name, ".mar"}, 32'(e.mar), 32'(a.mar));
      checkEqual({name, ".memData"}, 32'(e.memData), 32'(a.memData));
      checkEqual({name, ".brg"}, 32'(e.brg), 32'(a.brg));
      checkEqual({name, ".obus"}, 32'(e.obus), 32'(a.obus));
   endtask

   // Samples pre-edge values two edges after each step
   always @(posedge clk)
   begin
      actObs = '{mar: mar, memData: memData, brg: brg, obus: obus};
      // First cycle out of reset or init reads all zero
      if (clrD1 && !(rst || init))
         compareObs("clear", '0, actObs);
      if (stepD2)
      begin
         expObs = expQ.pop_front();
         compareObs(nameQ.pop_front(), expObs, actObs);
      end
      stepD2 = stepD1;
      stepD1 = step;
      clrD1  = rst || init;
   end

   ////////////////////
   // Stimulus
   ////////////////////

   // Entered and left 1 ns after a rising edge
   task automatic applyWord(kmcCram_t w, string name);
      logic [7:0] ibusVal;
      ibusVal = 8'($urandom);
      cram    = w;
      ibus    = ibusVal;
      step    = 1'b1;
      model   = refStep(model, w, ibusVal);
      expQ.push_back('{mar: model.mar, memData: model.ram[model.mar[9:0]],
                       brg: model.brg, obus: model.obus});
      nameQ.push_back(name);
      @(posedge clk);
      #1 step = 1'b0;
      @(posedge clk);
      #1;
   endtask

   // RAM survives init
   task automatic pulseInit();
      init       = 1'b1;
      model.mar  = '0;
      model.brg  = '0;
      model.obus = '0;
      @(posedge clk);
      #1 init = 1'b0;
      @(posedge clk);
      #1;
   endtask

   initial
   begin
      #(TimeoutNs);
      $display("Run timed out before the planned steps finished");
      $display("CHECKS FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      logic [9:0] addr;
      kmcAluOp_t  op;
      rst   = 1'b1;
      init  = 1'b0;
      step  = 1'b0;
      cram  = '0;
      ibus  = '0;
      model = '0;
      void'($urandom(32'h85f922a1));
      repeat (10) @(posedge clk);
      #1 rst = 1'b0;

      // Init in the middle of activity
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_BRG, MAR_LDLO, 8'h3c), "init_setup");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_OBUS, MAR_INC, 8'hc3), "init_setup");
      // Nonzero memData so init has something to clear
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_MEM, MAR_HOLD, 8'ha5), "init_setup");
      pulseInit();

      // MAR loads, JMP hold, then walk up to the wrap
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDLO, 8'($urandom)), "mar_ldlo");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDHI, 8'hff), "mar_ldhi");
      applyWord(mkWord(SRC_JMP, ALU_PASS, DST_OBUS, MAR_INC, 8'h5a), "mar_jmp");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDLO, 8'hff), "mar_ldlo");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDHI, 8'h03), "mar_ldhi");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_INC, 8'h00), "mar_inc_top");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDLO, 8'hff), "mar_ldlo");
      repeat (768)
         applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_INC, 8'h00), "mar_inc");
      applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_INC, 8'h00), "mar_wrap");

      // Every ALU function into OBUS and BRG
      for (int k = 0; k < 8; k++)
      begin
         op = kmcAluOp_t'(4'(k));
         repeat (AluTrials)
         begin
            applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_BRG, MAR_HOLD, 8'($urandom)), "alu_brg");
            applyWord(mkWord(SRC_IMMED, op, DST_OBUS, MAR_HOLD, 8'($urandom)),
                      $sformatf("alu_%s_obus", op.name()));
            applyWord(mkWord(SRC_IMMED, op, DST_BRG, MAR_HOLD, 8'($urandom)),
                      $sformatf("alu_%s_brg", op.name()));
         end
      end

      // Write then read back at random addresses
      repeat (MemTrials)
      begin
         addr = 10'($urandom);
         applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDHI, {6'd0, addr[9:8]}), "mem_addr");
         applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_NONE, MAR_LDLO, addr[7:0]), "mem_addr");
         applyWord(mkWord(SRC_IMMED, ALU_PASS, DST_MEM, MAR_HOLD, 8'($urandom)), "mem_write");
         applyWord(mkWord(SRC_MEM, ALU_PASS, DST_OBUS, MAR_HOLD, 8'h00), "mem_read");
      end

      // Random mix with one init halfway
      for (int i = 0; i < RandSteps; i++)
      begin
         if (i == RandSteps / 2)
            pulseInit();
         applyWord(mkWord(kmcSrc_t'(3'($urandom_range(0, 4))),
                          kmcAluOp_t'(4'($urandom_range(0, 7))),
                          kmcDst_t'(3'($urandom_range(0, 3))),
                          kmcMarOp_t'(2'($urandom_range(0, 3))),
                          8'($urandom)), "random");
      end

      repeat (3) @(posedge clk);
      if (expQ.size() != 0)
      begin
         $display("Some expected results were never compared");
         $display("CHECKS FAILED");
         $fatal(1, "Compare queue not drained");
      end
      else
      begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
+incdir+src
src/kmc_pkg.sv
src/kmcSrcSel.sv
src/kmcAlu.sv
src/kmcMem.sv
src/kmcDatapath.sv
dv/kmcDatapath_sva.sv
dv/kmcTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the KMC data path testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module kmcTb -o kmcSim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/kmcSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
